// ==== filelist.f ====
design/pdp8_word_pkg.sv
design/pdp8_state_pkg.sv
design/major_state_machine.sv
design/interrupt_control.sv
design/panel_control.sv
design/pdp8_sequencer_top.sv
testbench/pdp8_sequencer_tb.sv

// ==== Bender.yml ====
package:
  name: pdp8_sequencer

sources:
  - design/pdp8_word_pkg.sv
  - design/pdp8_state_pkg.sv
  - design/major_state_machine.sv
  - design/interrupt_control.sv
  - design/panel_control.sv
  - design/pdp8_sequencer_top.sv
  - target: test
    files:
      - testbench/pdp8_sequencer_tb.sv

// ==== testbench/pdp8_sequencer_tb.sv ====
`timescale 1ns/10ps

module pdp8_sequencer_tb
    import pdp8_word_pkg::*, pdp8_state_pkg::*;
;

    // about four times the cycles the stimulus below needs
    localparam int MAX_CYCLES = 2000;

    logic         clk = 1'b0;
    logic         reset;
    logic         examine_key;
    logic         deposit_key;
    logic         cont_key;
    logic         halt_key;
    logic         single_step;
    logic         int_req;
    pdp8_word_t   instruction;
    major_state_t state;
    logic         int_in_prog;
    logic         int_ena;

    // reference model of the sequencer
    major_state_t exp_state;
    logic         exp_iip;
    logic         exp_iip_d;
    logic         exp_ena;
    logic         exp_inh;
    logic         exp_cont;
    logic         exp_trig;
    logic         exp_halt;
    logic         grant;
    logic         ind;
    logic         hlt_op;
    logic         short_instr;
    opcode_t      op;

    integer       seed = 74167;
    integer       rnd;
    int           cycle_count = 0;
    pdp8_word_t   word;

    pdp8_sequencer_top pdp8_sequencer_top_inst (
        .clk         (clk),
        .reset       (reset),
        .examine_key (examine_key),
        .deposit_key (deposit_key),
        .cont_key    (cont_key),
        .halt_key    (halt_key),
        .single_step (single_step),
        .int_req     (int_req),
        .instruction (instruction),
        .state       (state),
        .int_in_prog (int_in_prog),
        .int_ena     (int_ena)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout: the sequencer did not reach the awaited state in %0d cycles",
                     MAX_CYCLES);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            exp_state <= H0;
            exp_iip   <= 1'b0;
            exp_iip_d <= 1'b0;
            exp_ena   <= 1'b0;
            exp_inh   <= 1'b0;
            exp_cont  <= 1'b0;
            exp_trig  <= 1'b0;
            exp_halt  <= 1'b0;
        end
        else
        begin
            grant       = int_req && exp_ena && !exp_inh;
            op          = instruction[0:2];
            ind         = instruction[3];
            hlt_op      = (op == OPCODE_OPR) && ind && (instruction[10:11] == 2'b10);
            short_instr = (op == OPCODE_IOT) || (op == OPCODE_OPR) || (op == OPCODE_JMP && !ind);

            exp_cont <= cont_key;
            exp_trig <= (examine_key || deposit_key) && (exp_state == H0);
            if (halt_key)
                exp_halt <= 1'b1;
            else if (exp_state == H0)
                exp_halt <= 1'b0;

            // enable drops one clock after interrupt entry
            exp_iip_d <= exp_iip;
            if (exp_iip && !exp_iip_d)
            begin
                exp_ena <= 1'b0;
                exp_inh <= 1'b0;
            end
            else if (exp_state == F3)
            begin
                exp_inh <= (instruction == IOT_ION);
                if (instruction == IOT_ION)
                    exp_ena <= 1'b1;
                else if (instruction == IOT_IOF)
                    exp_ena <= 1'b0;
            end

            if (exp_state == F0)
                exp_iip <= 1'b0;
            case (exp_state)
                F3:
                begin
                    if (!short_instr)
                        exp_state <= ind ? D0 : E0;
                    else if (exp_halt || hlt_op)
                        exp_state <= H0;
                    else if (grant && instruction != IOT_IOF)
                    begin
                        exp_iip   <= 1'b1;
                        exp_state <= E0;
                    end
                    else
                        exp_state <= F0;
                end
                D3:
                begin
                    if (op != OPCODE_JMP)
                        exp_state <= E0;
                    else if (grant)
                    begin
                        exp_iip   <= 1'b1;
                        exp_state <= E0;
                    end
                    else
                        exp_state <= exp_halt ? H0 : F0;
                end
                E3:
                begin
                    if (exp_halt)
                        exp_state <= H0;
                    else if (!exp_iip && grant)
                    begin
                        exp_iip   <= 1'b1;
                        exp_state <= E0;
                    end
                    else
                        exp_state <= F0;
                end
                H0:
                    exp_state <= exp_cont ? F0 : (exp_trig ? H1 : H0);
                H3:
                    exp_state <= exp_cont ? F0 : H0;
                default:
                begin
                    if (exp_state[1:0] != 2'd0 || !single_step || exp_cont)
                        exp_state <= major_state_t'(exp_state + 4'd1);
                end
            endcase
        end
    end

    task automatic report_mismatch(input string name, input logic [11:0] got,
                                   input logic [11:0] expected);
        $display("Fail %s got %h expected %h", name, got, expected);
        $display("TESTS FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    a_state: assert property (@(posedge clk) disable iff (reset) state == exp_state)
        else report_mismatch("state", $sampled(state), $sampled(exp_state));

    a_int_in_prog: assert property (@(posedge clk) disable iff (reset) int_in_prog == exp_iip)
        else report_mismatch("int_in_prog", $sampled(int_in_prog), $sampled(exp_iip));

    a_int_ena: assert property (@(posedge clk) disable iff (reset) int_ena == exp_ena)
        else report_mismatch("int_ena", $sampled(int_ena), $sampled(exp_ena));

    task automatic wait_for_state(input major_state_t target);
        while (state != target)
            @(negedge clk);
    endtask

    task automatic press_cont;
        @(negedge clk);
        cont_key = 1'b1;
        @(negedge clk);
        cont_key = 1'b0;
    endtask

    // word is loaded at F0 and held until the next F0 or H0
    task automatic run_instruction(input pdp8_word_t w);
        wait_for_state(F0);
        instruction = w;
        @(negedge clk);
        while (state != F0 && state != H0)
            @(negedge clk);
    endtask

    task automatic request_interrupt_during(input pdp8_word_t w);
        run_instruction(IOT_ION);
        int_req = 1'b1;
        run_instruction(12'o7000);
        run_instruction(w);
        int_req = 1'b0;
        run_instruction(12'o7000);
    endtask

    initial
    begin
        reset       = 1'b1;
        examine_key = 1'b0;
        deposit_key = 1'b0;
        cont_key    = 1'b0;
        halt_key    = 1'b0;
        single_step = 1'b0;
        int_req     = 1'b0;
        instruction = 12'o7000;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        press_cont;
        run_instruction(12'o7000);
        run_instruction(12'o6030);
        run_instruction(12'o5200);
        run_instruction(12'o5400);
        for (int i = 0; i < 16; i++)
        begin
            rnd = $random(seed);
            word = pdp8_word_t'(rnd[11:0]);
            word[0:2] = opcode_t'($unsigned($random(seed)) % 5);
            run_instruction(word);
        end
        run_instruction(12'o7402);
        press_cont;

        // single step through fetch, defer and execute
        wait_for_state(F0);
        instruction = 12'o1400;
        single_step = 1'b1;
        repeat (4) @(negedge clk);
        press_cont;
        wait_for_state(D0);
        repeat (3) @(negedge clk);
        press_cont;
        wait_for_state(E0);
        press_cont;
        wait_for_state(F0);
        single_step = 1'b0;

        request_interrupt_during(12'o7000);
        request_interrupt_during(12'o5400);
        request_interrupt_during(12'o1100);
        request_interrupt_during(IOT_IOF);

        // halt key while an instruction runs
        wait_for_state(F0);
        instruction = 12'o3050;
        wait_for_state(F1);
        halt_key = 1'b1;
        @(negedge clk);
        halt_key = 1'b0;
        wait_for_state(H0);

        @(negedge clk);
        examine_key = 1'b1;
        @(negedge clk);
        examine_key = 1'b0;
        wait_for_state(H3);
        wait_for_state(H0);
        deposit_key = 1'b1;
        @(negedge clk);
        deposit_key = 1'b0;
        wait_for_state(H3);
        wait_for_state(H0);

        press_cont;
        wait_for_state(F1);
        examine_key = 1'b1;
        @(negedge clk);
        examine_key = 1'b0;
        run_instruction(12'o7000);
        run_instruction(12'o7402);
        repeat (4) @(negedge clk);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== design/pdp8_sequencer_top.sv ====
`timescale 1ns/10ps

module pdp8_sequencer_top
    import pdp8_word_pkg::*, pdp8_state_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         examine_key,
    input  logic         deposit_key,
    input  logic         cont_key,
    input  logic         halt_key,
    input  logic         single_step,
    input  logic         int_req,
    input  pdp8_word_t   instruction,
    output major_state_t state,
    output logic         int_in_prog,
    output logic         int_ena
);

    logic halt;
    logic cont;
    logic trigger;
    logic int_inh;

    panel_control panel_control_inst (
        .clk         (clk),
        .reset       (reset),
        .examine_key (examine_key),
        .deposit_key (deposit_key),
        .cont_key    (cont_key),
        .halt_key    (halt_key),
        .state       (state),
        .halt        (halt),
        .cont        (cont),
        .trigger     (trigger)
    );

    interrupt_control interrupt_control_inst (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .instruction (instruction),
        .int_in_prog (int_in_prog),
        .int_ena     (int_ena),
        .int_inh     (int_inh)
    );

    major_state_machine major_state_machine_inst (
        .clk         (clk),
        .reset       (reset),
        .halt        (halt),
        .single_step (single_step),
        .cont        (cont),
        .int_req     (int_req),
        .int_ena     (int_ena),
        .int_inh     (int_inh),
        .trigger     (trigger),
        .instruction (instruction),
        .int_in_prog (int_in_prog),
        .state       (state)
    );

endmodule

// ==== design/panel_control.sv ====
`timescale 1ns/10ps

module panel_control
    import pdp8_state_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         examine_key,
    input  logic         deposit_key,
    input  logic         cont_key,
    input  logic         halt_key,
    input  major_state_t state,
    output logic         halt,
    output logic         cont,
    output logic         trigger
);

    logic panel_key;

    assign panel_key = examine_key | deposit_key;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            halt    <= 1'b0;
            cont    <= 1'b0;
            trigger <= 1'b0;
        end
        else
        begin
            cont <= cont_key;

            // examine/deposit ignored unless stopped and not leaving H0
            trigger <= panel_key && (state == H0) && !cont;

            if (halt_key)
                halt <= 1'b1;
            else if (state == H0)
                halt <= 1'b0;
        end
    end

    a_trigger_in_h0: assert property (@(posedge clk) disable iff (reset)
        trigger |-> (state == H0))
        else $error("trigger outside H0, state %0h", state);

endmodule

// ==== design/interrupt_control.sv ====
`timescale 1ns/10ps

module interrupt_control
    import pdp8_word_pkg::*, pdp8_state_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  major_state_t state,
    input  pdp8_word_t   instruction,
    input  logic         int_in_prog,
    output logic         int_ena,
    output logic         int_inh
);

    logic int_in_prog_d;
    logic int_entry;

    assign int_entry = int_in_prog & ~int_in_prog_d;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            int_ena       <= 1'b0;
            int_inh       <= 1'b0;
            int_in_prog_d <= 1'b0;
        end
        else
        begin
            int_in_prog_d <= int_in_prog;

            if (int_entry)
            begin
                // entry turns the system off
                int_ena <= 1'b0;
                int_inh <= 1'b0;
            end
            else if (state == F3)
            begin
                if (instruction == IOT_ION)
                begin
                    // enable waits one more instruction
                    int_ena <= 1'b1;
                    int_inh <= 1'b1;
                end
                else
                begin
                    int_inh <= 1'b0;
                    if (instruction == IOT_IOF)
                        int_ena <= 1'b0;
                end
            end
        end
    end

    a_inh_needs_ena: assert property (@(posedge clk) disable iff (reset)
        int_inh |-> int_ena)
        else $error("int_inh set with int_ena clear");

endmodule

// ==== design/major_state_machine.sv ====
`timescale 1ns/10ps

module major_state_machine
    import pdp8_word_pkg::*, pdp8_state_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         halt,
    input  logic         single_step,
    input  logic         cont,
    input  logic         int_req,
    input  logic         int_ena,
    input  logic         int_inh,
    input  logic         trigger,
    input  pdp8_word_t   instruction,
    output logic         int_in_prog,
    output major_state_t state
);

    logic int_grant;
    logic step_ok;
    major_state_t next_phase;

    assign int_grant  = int_req & int_ena & ~int_inh;
    // phase 0 holds in single step until continue
    assign step_ok    = !is_phase0(state) || !single_step || cont;
    assign next_phase = major_state_t'(state + 4'd1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= H0;
            int_in_prog <= 1'b0;
        end
        else
        begin
            if (state == F0)
                int_in_prog <= 1'b0;

            case (state)
                F3:
                begin
                    if (!ends_in_fetch(instruction))
                        state <= is_indirect(instruction) ? D0 : E0;
                    else if (halt || is_hlt(instruction))
                        state <= H0;
                    // an IOF in this slot wins over the pending request
                    else if (int_grant && (instruction != IOT_IOF))
                    begin
                        int_in_prog <= 1'b1;
                        state       <= E0;
                    end
                    else
                        state <= F0;
                end

                D3:
                begin
                    if (opcode_of(instruction) == OPCODE_JMP)
                    begin
                        // jmp i ends here
                        if (int_grant)
                        begin
                            int_in_prog <= 1'b1;
                            state       <= E0;
                        end
                        else if (halt)
                            state <= H0;
                        else
                            state <= F0;
                    end
                    else
                        state <= E0;
                end

                E3:
                begin
                    if (halt)
                        state <= H0;
                    else if (int_in_prog)
                        state <= F0;
                    else if (int_grant)
                    begin
                        int_in_prog <= 1'b1;
                        state       <= E0;
                    end
                    else
                        state <= F0;
                end

                H0:
                begin
                    if (cont)
                        state <= F0;
                    else if (trigger)
                        state <= H1;
                    else
                        state <= H0;
                end

                H3:
                begin
                    if (cont)
                        state <= F0;
                    else
                        state <= H0;
                end

                // phases 0 to 2 of F, D and E, plus H1 and H2
                default:
                begin
                    if (step_ok)
                        state <= next_phase;
                end
            endcase
        end
    end

    a_mid_phase_advance: assert property (@(posedge clk) disable iff (reset)
        (!is_phase0(state) && !is_phase3(state)) |=>
            (state == major_state_t'($past(state) + 4'd1)))
        else $error("state %0h did not advance one phase", $past(state));

    a_int_entry_phase3: assert property (@(posedge clk) disable iff (reset)
        $rose(int_in_prog) |-> is_phase3($past(state)))
        else $error("interrupt entered outside phase 3");

endmodule

// ==== design/pdp8_state_pkg.sv ====
package pdp8_state_pkg;

    // low two bits carry the phase, high two bits the major cycle
    typedef enum logic [3:0] {
        F0 = 4'd0,
        F1 = 4'd1,
        F2 = 4'd2,
        F3 = 4'd3,
        D0 = 4'd4,
        D1 = 4'd5,
        D2 = 4'd6,
        D3 = 4'd7,
        E0 = 4'd8,
        E1 = 4'd9,
        E2 = 4'd10,
        E3 = 4'd11,
        H0 = 4'd12,
        H1 = 4'd13,
        H2 = 4'd14,
        H3 = 4'd15
    } major_state_t;

    function automatic logic is_phase0(major_state_t s);
        return s[1:0] == 2'd0;
    endfunction

    function automatic logic is_phase3(major_state_t s);
        return s[1:0] == 2'd3;
    endfunction

endpackage

// ==== design/pdp8_word_pkg.sv ====
package pdp8_word_pkg;

    // bit 0 is the msb, numbered left to right
    typedef logic [0:11] pdp8_word_t;
    typedef logic [0:2] opcode_t;

    localparam opcode_t OPCODE_JMP = 3'd5;
    localparam opcode_t OPCODE_IOT = 3'd6;
    localparam opcode_t OPCODE_OPR = 3'd7;

    localparam pdp8_word_t IOT_ION = 12'o6001;
    localparam pdp8_word_t IOT_IOF = 12'o6002;

    function automatic opcode_t opcode_of(pdp8_word_t word);
        return word[0:2];
    endfunction

    function automatic logic is_indirect(pdp8_word_t word);
        return word[3];
    endfunction

    // group 2 operate with the halt bit
    function automatic logic is_hlt(pdp8_word_t word);
        return (opcode_of(word) == OPCODE_OPR) && word[3] && (word[10:11] == 2'b10);
    endfunction

    // iot, opr and direct jmp finish inside the fetch cycle
    function automatic logic ends_in_fetch(pdp8_word_t word);
        opcode_t op;
        op = opcode_of(word);
        return (op == OPCODE_IOT) || (op == OPCODE_OPR) ||
               ((op == OPCODE_JMP) && !is_indirect(word));
    endfunction

endpackage
